// ==== compile.f ====
+incdir+source
source/core_pkg.sv
source/core_ifs.sv
source/fetch_stage.sv
source/decode_execute.sv
source/memory_writeback.sv
source/core_top.sv
testbench/core_assertions.sv
testbench/core_checker.sv
testbench/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vcore_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
exit 1

// ==== source/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Architectural sizes of the integer core
`define CORE_XLEN 32
`define CORE_REG_COUNT 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// ==== source/core_ifs.sv ====
`timescale 1ns/1ps

// Fetched instruction towards decode and redirect back to fetch
interface fetch_if;
	core_pkg::inst_t inst;
	core_pkg::addr_t pc;
	logic valid;
	logic take;
	logic redirect;
	core_pkg::addr_t redirect_pc;

	modport producer (
		output inst, pc, valid,
		input take, redirect, redirect_pc
	);

	modport consumer (
		input inst, pc, valid,
		output take, redirect, redirect_pc
	);
endinterface

// Issued operation towards the memory stage and writeback to the register file
interface mem_op_if;
	logic issue;
	core_pkg::mem_kind_t kind;
	core_pkg::word_t addr_or_result;
	core_pkg::word_t store_data;
	core_pkg::reg_idx_t rd;
	logic rf_wen;
	logic done;
	logic wb_en;
	core_pkg::reg_idx_t wb_rd;
	core_pkg::word_t wb_data;

	modport producer (
		output issue, kind, addr_or_result, store_data, rd, rf_wen,
		input done, wb_en, wb_rd, wb_data
	);

	modport consumer (
		input issue, kind, addr_or_result, store_data, rd, rf_wen,
		output done, wb_en, wb_rd, wb_data
	);
endinterface

// ==== source/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0] word_t;
	typedef logic [`CORE_XLEN-1:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_kind_t;

	// State machines
	typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQ, FETCH_DROP, FETCH_FULL} fetch_state_t;
	typedef enum logic [1:0] {ISSUE_RUN, ISSUE_WAIT_MEM, ISSUE_HALT} issue_state_t;
	typedef enum logic [1:0] {MEM_IDLE, MEM_REQ, MEM_DROP, MEM_WB} mem_state_t;

endpackage

// ==== source/core_top.sv ====
`timescale 1ns/1ps

module core_top (
	input logic clk,
	input logic arst_n,
	output logic imem_req,
	output core_pkg::addr_t imem_addr,
	input logic imem_ack,
	input core_pkg::inst_t imem_rdata,
	output logic dmem_req,
	output logic dmem_we,
	output core_pkg::addr_t dmem_addr,
	output core_pkg::word_t dmem_wdata,
	input logic dmem_ack,
	input core_pkg::word_t dmem_rdata,
	output logic halted
);

	fetch_if i_fetch_if ();
	mem_op_if i_mem_op_if ();

	// ******************************************************************
	// Fetch
	// ******************************************************************
	fetch_stage i_fetch_stage (
		.clk(clk),
		.arst_n(arst_n),
		.fetch(i_fetch_if.producer),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_rdata(imem_rdata)
	);

	// ******************************************************************
	// Decode, execute and issue
	// ******************************************************************
	decode_execute i_decode_execute (
		.clk(clk),
		.arst_n(arst_n),
		.fetch(i_fetch_if.consumer),
		.mem_op(i_mem_op_if.producer),
		.halted(halted)
	);

	// ******************************************************************
	// Memory access and writeback
	// ******************************************************************
	memory_writeback i_memory_writeback (
		.clk(clk),
		.arst_n(arst_n),
		.mem_op(i_mem_op_if.consumer),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_ack(dmem_ack),
		.dmem_rdata(dmem_rdata)
	);

endmodule

// ==== source/decode_execute.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module decode_execute (
	input logic clk,
	input logic arst_n,
	fetch_if.consumer fetch,
	mem_op_if.producer mem_op,
	output logic halted
);

	core_pkg::word_t regs [`CORE_REG_COUNT];
	core_pkg::issue_state_t state;

	core_pkg::reg_idx_t rd, rs1, rs2;
	logic [2:0] funct3;
	core_pkg::word_t imm_i, imm_s, imm_b, imm_j, imm_u;
	core_pkg::word_t rs1_val, rs2_val, alu_b, alu_result;
	core_pkg::alu_op_t dec_alu_op;
	core_pkg::mem_kind_t dec_kind;
	logic dec_rf_wen, dec_use_imm, is_branch, is_jal, br_taken, halt_jal, take;

	// ******************************************************************
	// Register file
	// ******************************************************************
	always_ff @(posedge clk) begin
		if (mem_op.wb_en && mem_op.wb_rd != '0)
			regs[mem_op.wb_rd] <= mem_op.wb_data;
	end

	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

	// ******************************************************************
	// Decode
	// ******************************************************************
	assign rd = fetch.inst[11:7];
	assign funct3 = fetch.inst[14:12];
	assign rs1 = fetch.inst[19:15];
	assign rs2 = fetch.inst[24:20];

	assign imm_i = {{20{fetch.inst[31]}}, fetch.inst[31:20]};
	assign imm_s = {{20{fetch.inst[31]}}, fetch.inst[31:25], fetch.inst[11:7]};
	assign imm_b = {{19{fetch.inst[31]}}, fetch.inst[31], fetch.inst[7],
		fetch.inst[30:25], fetch.inst[11:8], 1'b0};
	assign imm_j = {{11{fetch.inst[31]}}, fetch.inst[31], fetch.inst[19:12],
		fetch.inst[20], fetch.inst[30:21], 1'b0};
	assign imm_u = {fetch.inst[31:12], 12'b0};

	always_comb begin
		dec_alu_op = core_pkg::ALU_ADD;
		dec_kind = core_pkg::MEM_NONE;
		dec_rf_wen = 1'b0;
		dec_use_imm = 1'b1;
		alu_b = imm_i;
		is_branch = 1'b0;
		is_jal = 1'b0;
		case (fetch.inst[6:0])
			core_pkg::OPC_OP_IMM: dec_rf_wen = 1'b1;
			core_pkg::OPC_OP: begin
				dec_rf_wen = 1'b1;
				dec_use_imm = 1'b0;
				case (funct3)
					3'b000: dec_alu_op = fetch.inst[30] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
					3'b010: dec_alu_op = core_pkg::ALU_SLT;
					3'b100: dec_alu_op = core_pkg::ALU_XOR;
					3'b110: dec_alu_op = core_pkg::ALU_OR;
					3'b111: dec_alu_op = core_pkg::ALU_AND;
					default: dec_alu_op = core_pkg::ALU_ADD;
				endcase
			end
			core_pkg::OPC_LUI: begin
				dec_alu_op = core_pkg::ALU_PASS_B;
				dec_rf_wen = 1'b1;
				alu_b = imm_u;
			end
			core_pkg::OPC_LOAD: begin
				dec_kind = core_pkg::MEM_LOAD;
				dec_rf_wen = 1'b1;
			end
			core_pkg::OPC_STORE: begin
				dec_kind = core_pkg::MEM_STORE;
				alu_b = imm_s;
			end
			core_pkg::OPC_BRANCH: is_branch = 1'b1;
			core_pkg::OPC_JAL: begin
				is_jal = 1'b1;
				dec_rf_wen = 1'b1;
			end
			default: ;
		endcase
		if (!dec_use_imm)
			alu_b = rs2_val;
	end

	// ******************************************************************
	// ALU and branch resolution
	// ******************************************************************
	always_comb begin
		case (dec_alu_op)
			core_pkg::ALU_SUB: alu_result = rs1_val - alu_b;
			core_pkg::ALU_AND: alu_result = rs1_val & alu_b;
			core_pkg::ALU_OR: alu_result = rs1_val | alu_b;
			core_pkg::ALU_XOR: alu_result = rs1_val ^ alu_b;
			core_pkg::ALU_SLT: alu_result = {31'b0, $signed(rs1_val) < $signed(alu_b)};
			core_pkg::ALU_PASS_B: alu_result = alu_b;
			default: alu_result = rs1_val + alu_b;
		endcase
	end

	// BEQ has funct3 000 and BNE has 001
	assign br_taken = is_branch && ((rs1_val == rs2_val) != funct3[0]);
	assign halt_jal = is_jal && (imm_j == '0);

	assign take = fetch.valid && (state == core_pkg::ISSUE_RUN);
	assign fetch.take = take;
	assign fetch.redirect = take && (br_taken || is_jal);
	assign fetch.redirect_pc = fetch.pc + (is_jal ? imm_j : imm_b);

	assign halted = (state == core_pkg::ISSUE_HALT);

	// ******************************************************************
	// Issue FSM
	// ******************************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= core_pkg::ISSUE_RUN;
			mem_op.issue <= 1'b0;
		end else begin
			mem_op.issue <= take;
			case (state)
				core_pkg::ISSUE_RUN:
					if (take)
						state <= halt_jal ? core_pkg::ISSUE_HALT : core_pkg::ISSUE_WAIT_MEM;
				core_pkg::ISSUE_WAIT_MEM:
					if (mem_op.done)
						state <= core_pkg::ISSUE_RUN;
				default: state <= core_pkg::ISSUE_HALT;
			endcase
		end
	end

	// Operation handed to the memory stage
	always_ff @(posedge clk) begin
		if (take) begin
			mem_op.kind <= dec_kind;
			mem_op.addr_or_result <= is_jal ? fetch.pc + 32'd4 : alu_result;
			mem_op.store_data <= rs2_val;
			mem_op.rd <= rd;
			mem_op.rf_wen <= dec_rf_wen;
		end
	end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_stage (
	input logic clk,
	input logic arst_n,
	fetch_if.producer fetch,
	output logic imem_req,
	output core_pkg::addr_t imem_addr,
	input logic imem_ack,
	input core_pkg::inst_t imem_rdata
);

	core_pkg::fetch_state_t state;
	core_pkg::addr_t pc_q;
	logic buf_valid;
	core_pkg::inst_t buf_inst;
	core_pkg::addr_t buf_pc;

	assign imem_req = (state == core_pkg::FETCH_REQ);
	assign imem_addr = pc_q;

	assign fetch.valid = buf_valid;
	assign fetch.inst = buf_inst;
	assign fetch.pc = buf_pc;

	// ******************************************************************
	// Four-phase handshake and one-entry buffer
	// ******************************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= core_pkg::FETCH_IDLE;
			pc_q <= `CORE_RESET_PC;
			buf_valid <= 1'b0;
		end else begin
			if (fetch.take || fetch.redirect)
				buf_valid <= 1'b0;
			case (state)
				core_pkg::FETCH_IDLE: begin
					if (fetch.redirect)
						pc_q <= fetch.redirect_pc;
					if (!imem_ack)
						state <= core_pkg::FETCH_REQ;
				end
				core_pkg::FETCH_REQ: begin
					// Buffer stays empty while the request runs
					if (imem_ack) begin
						state <= core_pkg::FETCH_DROP;
						buf_valid <= 1'b1;
						pc_q <= pc_q + 32'd4;
					end
				end
				core_pkg::FETCH_DROP: begin
					if (fetch.redirect)
						pc_q <= fetch.redirect_pc;
					if (!imem_ack) begin
						if (buf_valid && !fetch.take && !fetch.redirect)
							state <= core_pkg::FETCH_FULL;
						else
							state <= core_pkg::FETCH_REQ;
					end
				end
				default: begin
					if (fetch.redirect)
						pc_q <= fetch.redirect_pc;
					if (fetch.take || fetch.redirect)
						state <= core_pkg::FETCH_REQ;
				end
			endcase
		end
	end

	// Buffer payload
	always_ff @(posedge clk) begin
		if (state == core_pkg::FETCH_REQ && imem_ack) begin
			buf_inst <= imem_rdata;
			buf_pc <= pc_q;
		end
	end

endmodule

// ==== source/memory_writeback.sv ====
`timescale 1ns/1ps

module memory_writeback (
	input logic clk,
	input logic arst_n,
	mem_op_if.consumer mem_op,
	output logic dmem_req,
	output logic dmem_we,
	output core_pkg::addr_t dmem_addr,
	output core_pkg::word_t dmem_wdata,
	input logic dmem_ack,
	input core_pkg::word_t dmem_rdata
);

	core_pkg::mem_state_t state;
	core_pkg::mem_kind_t kind_q;
	core_pkg::word_t addr_q;
	core_pkg::word_t data_q;
	core_pkg::word_t load_q;
	core_pkg::reg_idx_t rd_q;
	logic rf_wen_q;

	// ******************************************************************
	// Data-side handshake
	// ******************************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= core_pkg::MEM_IDLE;
		end else begin
			case (state)
				core_pkg::MEM_IDLE:
					if (mem_op.issue)
						state <= (mem_op.kind == core_pkg::MEM_NONE) ?
							core_pkg::MEM_WB : core_pkg::MEM_REQ;
				core_pkg::MEM_REQ:
					if (dmem_ack)
						state <= core_pkg::MEM_DROP;
				core_pkg::MEM_DROP:
					if (!dmem_ack)
						state <= core_pkg::MEM_WB;
				default: state <= core_pkg::MEM_IDLE;
			endcase
		end
	end

	// Latched operation and load data
	always_ff @(posedge clk) begin
		if (state == core_pkg::MEM_IDLE && mem_op.issue) begin
			kind_q <= mem_op.kind;
			addr_q <= mem_op.addr_or_result;
			data_q <= mem_op.store_data;
			rd_q <= mem_op.rd;
			rf_wen_q <= mem_op.rf_wen;
		end
		if (state == core_pkg::MEM_REQ && dmem_ack)
			load_q <= dmem_rdata;
	end

	assign dmem_req = (state == core_pkg::MEM_REQ);
	assign dmem_we = dmem_req && (kind_q == core_pkg::MEM_STORE);
	assign dmem_addr = addr_q;
	assign dmem_wdata = data_q;

	// ******************************************************************
	// Writeback
	// ******************************************************************
	assign mem_op.done = (state == core_pkg::MEM_WB);
	assign mem_op.wb_en = mem_op.done && rf_wen_q && (kind_q != core_pkg::MEM_STORE);
	assign mem_op.wb_rd = rd_q;
	assign mem_op.wb_data = (kind_q == core_pkg::MEM_LOAD) ? load_q : addr_q;

endmodule

// ==== testbench/core_assertions.sv ====
`timescale 1ns/1ps

module core_assertions (
	input logic clk,
	input logic arst_n,
	input logic imem_req,
	input logic imem_ack,
	input core_pkg::addr_t imem_addr,
	input logic dmem_req,
	input logic dmem_we,
	input logic dmem_ack,
	input core_pkg::addr_t dmem_addr,
	input core_pkg::word_t dmem_wdata
);

	// Request stays up until the memory answers
	imem_hold: assert property (@(posedge clk) disable iff (!arst_n)
		imem_req && !imem_ack |=> imem_req)
		else $error("imem_req dropped before imem_ack");
	dmem_hold: assert property (@(posedge clk) disable iff (!arst_n)
		dmem_req && !dmem_ack |=> dmem_req)
		else $error("dmem_req dropped before dmem_ack");

	// Address and write data frozen during a request
	imem_stable: assert property (@(posedge clk) disable iff (!arst_n)
		imem_req && !imem_ack |=> $stable(imem_addr))
		else $error("imem_addr changed while imem_req was high");
	dmem_stable: assert property (@(posedge clk) disable iff (!arst_n)
		dmem_req && !dmem_ack |=> $stable(dmem_addr) && $stable(dmem_we) && $stable(dmem_wdata))
		else $error("dmem address, write enable or data changed while dmem_req was high");

	// No new request before ack has fallen
	imem_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(imem_req) |-> !imem_ack)
		else $error("imem_req rose while imem_ack was still high");
	dmem_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(dmem_req) |-> !dmem_ack)
		else $error("dmem_req rose while dmem_ack was still high");

endmodule

bind core_top core_assertions i_core_assertions (.*);

// ==== testbench/core_checker.sv ====
`timescale 1ns/1ps

module core_checker (
	input logic clk,
	input logic arst_n,
	input logic dmem_req,
	input logic dmem_we,
	input core_pkg::addr_t dmem_addr,
	input core_pkg::word_t dmem_wdata
);

	string exp_name [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int pass_count = 0;
	int fail_count = 0;
	logic req_q;

	task automatic expect_store(input string name, input logic [31:0] addr,
		input logic [31:0] data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic check_write(input logic [31:0] addr, input logic [31:0] data);
		string name;
		logic [31:0] want_addr;
		logic [31:0] want_data;
		if (exp_name.size() == 0) begin
			$display("unexpected write of %h to address %h after the last expected store",
				data, addr);
			fail_count++;
		end else begin
			name = exp_name.pop_front();
			want_addr = exp_addr.pop_front();
			want_data = exp_data.pop_front();
			if (addr == want_addr && data == want_data) begin
				$display("pass %s", name);
				pass_count++;
			end else begin
				$display("error %s expected %h at %h, actual %h at %h",
					name, want_data, want_addr, data, addr);
				fail_count++;
			end
		end
	endtask

	// Stores still queued when the core halts were never written
	task automatic report_missing();
		while (exp_name.size() > 0) begin
			$display("missing store for test %s, the core halted without writing it",
				exp_name.pop_front());
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
			fail_count++;
		end
	endtask

	task automatic print_summary();
		$display("tests passed %0d failed %0d", pass_count, fail_count);
	endtask

	// One check per write at the rising edge of req
	always @(posedge clk) begin
		if (!arst_n) begin
			req_q <= 1'b0;
		end else begin
			req_q <= dmem_req;
			if (dmem_req && !req_q && dmem_we)
				check_write(dmem_addr, dmem_wdata);
		end
	end

endmodule

// ==== testbench/core_golden.txt ====
# I <byte addr> <instruction> | D <byte addr> <initial word>
# E <test name> <store byte addr> <store data>, stores in program order
# ALU, x10 holds the data base 0x100
I 00000000 10000513
I 00000004 00500093
I 00000008 ffd00113
I 0000000c 00152023
I 00000010 00252223
I 00000014 002081b3
I 00000018 00352423
I 0000001c 40110233
I 00000020 00452623
I 00000024 123453b7
I 00000028 67838413
I 0000002c 00752823
I 00000030 00852a23
I 00000034 0f000493
I 00000038 009472b3
I 0000003c 00552c23
I 00000040 00946333
I 00000044 00652e23
I 00000048 009445b3
I 0000004c 02b52023
I 00000050 00112633
I 00000054 0020a6b3
I 00000058 02c52223
I 0000005c 02d52423
# Write to x0, then loads
I 00000060 04d00013
I 00000064 02052623
I 00000068 10052703
I 0000006c 02e52823
I 00000070 10452783
I 00000074 001787b3
I 00000078 02f52a23
I 0000007c 02852c23
I 00000080 03852803
I 00000084 03052e23
# Branches, a counted loop and a linking JAL, wrong paths at 94, a8, cc, d0
I 00000088 00208463
I 0000008c 04152023
I 00000090 00108463
I 00000094 04252223
I 00000098 04452223
I 0000009c 00109463
I 000000a0 04352423
I 000000a4 00209463
I 000000a8 04152623
I 000000ac 04552623
I 000000b0 00300893
I 000000b4 00000913
I 000000b8 00190933
I 000000bc fff88893
I 000000c0 fe089ce3
I 000000c4 05252823
I 000000c8 00c009ef
I 000000cc 04152a23
I 000000d0 04252a23
I 000000d4 05352a23
I 000000d8 0000006f
D 00000200 cafebabe
D 00000204 00000011
E addi_pos 00000100 00000005
E addi_neg 00000104 fffffffd
E add 00000108 00000002
E sub 0000010c fffffff8
E lui 00000110 12345000
E addi_hi 00000114 12345678
E and 00000118 00000070
E or 0000011c 123456f8
E xor 00000120 12345688
E slt_true 00000124 00000001
E slt_false 00000128 00000000
E x0_zero 0000012c 00000000
E lw_init 00000130 cafebabe
E lw_add 00000134 00000016
E sw_data 00000138 12345678
E lw_back 0000013c 12345678
E beq_nt 00000140 00000005
E beq_t 00000144 fffffff8
E bne_nt 00000148 00000002
E bne_t 0000014c 00000070
E loop 00000150 0000000f
E jal_link 00000154 000000cc

// ==== testbench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

	localparam int MEM_WORDS = 1024;
	localparam int HALT_TIMEOUT = 5000;

	logic clk = 1'b0;
	logic arst_n;
	logic imem_req;
	core_pkg::addr_t imem_addr;
	logic imem_ack;
	core_pkg::inst_t imem_rdata;
	logic dmem_req;
	logic dmem_we;
	core_pkg::addr_t dmem_addr;
	core_pkg::word_t dmem_wdata;
	logic dmem_ack;
	core_pkg::word_t dmem_rdata;
	logic halted;

	core_pkg::word_t imem [MEM_WORDS];
	core_pkg::word_t dmem [MEM_WORDS];
	logic [31:0] rnd_state = 32'h22ea;
	int i_left = -1;
	int d_left = -1;
	int load_errors;
	int cycles;

	always #20 clk = ~clk;

	core_top i_core_top (
		.clk(clk),
		.arst_n(arst_n),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_rdata(imem_rdata),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_ack(dmem_ack),
		.dmem_rdata(dmem_rdata),
		.halted(halted)
	);

	core_checker i_core_checker (
		.clk(clk),
		.arst_n(arst_n),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Unwritten words differ at every byte address
	function automatic logic [31:0] fill_word(input logic [31:0] base, input logic [31:0] addr);
		return base ^ addr ^ (addr << 16);
	endfunction

	// *********************************************************************
	// Golden file with program, initial data and expected stores
	// *********************************************************************
	task automatic load_golden();
		int fd;
		int n;
		string tag;
		string name;
		string rest;
		logic [31:0] addr;
		logic [31:0] word;
		fd = $fopen("testbench/core_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/core_golden.txt for reading");
			load_errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", tag);
				if (n != 1)
					break;
				if (tag == "#") begin
					n = $fgets(rest, fd);
				end else if (tag == "I") begin
					n = $fscanf(fd, "%h %h", addr, word);
					imem[addr[11:2]] = word;
				end else if (tag == "D") begin
					n = $fscanf(fd, "%h %h", addr, word);
					dmem[addr[11:2]] = word;
				end else if (tag == "E") begin
					n = $fscanf(fd, "%s %h %h", name, addr, word);
					i_core_checker.expect_store(name, addr, word);
				end else begin
					$display("unknown line type %s in the golden file", tag);
					load_errors++;
				end
			end
			$fclose(fd);
		end
	endtask

	// Shared random source advanced once per cycle
	always @(posedge clk)
		rnd_state <= xorshift32(rnd_state);

	// *********************************************************************
	// Memory responders with 0 to 3 cycles of extra ack delay
	// *********************************************************************
	always @(posedge clk) begin
		if (!arst_n) begin
			imem_ack <= 1'b0;
			i_left = -1;
		end else if (imem_ack) begin
			if (!imem_req)
				imem_ack <= 1'b0;
		end else if (imem_req) begin
			if (i_left < 0)
				i_left = int'(rnd_state[1:0]);
			if (i_left == 0) begin
				imem_ack <= 1'b1;
				imem_rdata <= imem[imem_addr[11:2]];
			end
			i_left = i_left - 1;
		end
	end

	always @(posedge clk) begin
		if (!arst_n) begin
			dmem_ack <= 1'b0;
			d_left = -1;
		end else if (dmem_ack) begin
			if (!dmem_req)
				dmem_ack <= 1'b0;
		end else if (dmem_req) begin
			if (d_left < 0)
				d_left = int'(rnd_state[9:8]);
			if (d_left == 0) begin
				dmem_ack <= 1'b1;
				if (dmem_we)
					dmem[dmem_addr[11:2]] = dmem_wdata;
				else
					dmem_rdata <= dmem[dmem_addr[11:2]];
			end
			d_left = d_left - 1;
		end
	end

	// *********************************************************************
	// Main sequence
	// *********************************************************************
	initial begin
		arst_n <= 1'b0;
		imem_ack <= 1'b0;
		imem_rdata <= '0;
		dmem_ack <= 1'b0;
		dmem_rdata <= '0;
		load_errors = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = fill_word(32'h0bad_0000, i * 4);
			dmem[i] = fill_word(32'h5ca1_0000, i * 4);
		end
		load_golden();
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT && load_errors == 0) begin
			@(negedge clk);
			cycles++;
		end
		if (load_errors != 0)
			$display("golden file could not be loaded, the program was not run");
		else if (!halted)
			$display("timeout, halted did not rise within %0d cycles", HALT_TIMEOUT);
		else
			i_core_checker.report_missing();
		i_core_checker.print_summary();
		if (load_errors == 0 && halted && i_core_checker.fail_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
